/* verilog.f */
+incdir+verilog
verilog/aesTypesPkg.sv
verilog/aesMathPkg.sv
verilog/sBoxLayer.sv
verilog/keySchedule.sv
verilog/encryptRound.sv
verilog/decryptRound.sv
verilog/roundController.sv
verilog/aesCore.sv
bench/aesCoreTb.sv

/* bench/aesCoreTb.sv */
`timescale 1ns/100ps
`include "aes_settings.svh"

module aesCoreTb;

    import aesTypesPkg::*;

    // accepting edge counted as edge 1
    localparam int ExpectedLatency = `AES_ROUNDS + 2;
    localparam int DoneTimeout     = 40;

    localparam logic [127:0] KeyA    = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] PlainA  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] CipherA = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam logic [127:0] KeyB    = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam logic [127:0] PlainB  = 128'h3243f6a8885a308d313198a2e0370734;
    localparam logic [127:0] CipherB = 128'h3925841d02dc09fbdc118597196a0b32;

    logic        clk;
    logic        rst;
    logic        start;
    aesRequest_t request;
    state_t      blockOut;
    logic        done;

    integer seed;
    int     testErrors;
    int     passCount;
    int     failCount;

    aesCore UUT (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .request  (request),
        .blockOut (blockOut),
        .done     (done)
    );

    always #20 clk = ~clk;

    task automatic checkValue(input string testName, input logic [127:0] expected,
                              input logic [127:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %h, actual %h", testName, expected, actual);
            testErrors++;
        end
    endtask

    task automatic finishTest(input string testName);
        if (testErrors == 0) begin
            $display("%s: passed", testName);
            passCount++;
        end else begin
            $display("%s: failed with %0d errors", testName, testErrors);
            failCount++;
        end
        testErrors = 0;
    endtask

    // called right after a rising edge, leaves start high
    task automatic driveRequest(input logic decrypt, input logic [127:0] key,
                                input logic [127:0] block);
        aesRequest_t req;
        req.decrypt = decrypt;
        req.key     = key;
        req.block   = block;
        request <= req;
        start   <= 1'b1;
    endtask

    // returns right after the accepting edge
    task automatic startOp(input logic decrypt, input logic [127:0] key,
                           input logic [127:0] block);
        @(posedge clk);
        driveRequest(decrypt, key, block);
        @(posedge clk);
        start <= 1'b0;
    endtask

    // done is sampled on the falling edge
    task automatic waitDone(input string testName, output int cycles, output bit seen);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DoneTimeout) begin
            @(negedge clk);
            cycles++;
            if (done === 1'b1) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("%s: no done pulse within %0d cycles", testName, DoneTimeout);
            testErrors++;
        end
    endtask

    task automatic runOp(input string testName, input logic decrypt,
                         input logic [127:0] key, input logic [127:0] block,
                         output logic [127:0] result);
        int cycles;
        bit seen;
        startOp(decrypt, key, block);
        waitDone(testName, cycles, seen);
        result = blockOut;
    endtask

    task automatic randomValue(output logic [127:0] value);
        value = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    task automatic resetState();
        @(negedge clk);
        checkValue("reset done", 1'b0, done);
        checkValue("reset blockOut", '0, blockOut);
        finishTest("reset");
    endtask

    task automatic fipsVector(input string testName, input logic [127:0] key,
                              input logic [127:0] plain, input logic [127:0] cipher);
        logic [127:0] result;
        runOp(testName, 1'b0, key, plain, result);
        checkValue({testName, " encrypt"}, cipher, result);
        runOp(testName, 1'b1, key, cipher, result);
        checkValue({testName, " decrypt"}, plain, result);
        finishTest(testName);
    endtask

    task automatic randomRoundTrip();
        logic [127:0] key;
        logic [127:0] block;
        logic [127:0] cipher;
        logic [127:0] result;
        for (int i = 0; i < 8; i++) begin
            randomValue(key);
            randomValue(block);
            runOp("random round trip", 1'b0, key, block, cipher);
            runOp("random round trip", 1'b1, key, cipher, result);
            checkValue($sformatf("random round trip %0d", i), block, result);
        end
        finishTest("random round trip");
    endtask

    task automatic doneTiming();
        int cycles;
        bit seen;
        @(posedge clk);
        driveRequest(1'b0, KeyA, PlainA);
        @(posedge clk);
        // start stays high, so the next request is taken on the edge right after done
        driveRequest(1'b0, KeyB, PlainB);
        waitDone("timing", cycles, seen);
        checkValue("timing latency", ExpectedLatency, cycles);
        checkValue("timing result", CipherA, blockOut);
        @(posedge clk);
        driveRequest(1'b1, KeyA, CipherA);
        waitDone("back to back", cycles, seen);
        checkValue("back to back latency 1", ExpectedLatency, cycles);
        checkValue("back to back result 1", CipherB, blockOut);
        @(posedge clk);
        start <= 1'b0;
        waitDone("back to back", cycles, seen);
        checkValue("back to back latency 2", ExpectedLatency, cycles);
        checkValue("back to back result 2", PlainA, blockOut);
        @(negedge clk);
        checkValue("timing done width", 1'b0, done);
        finishTest("timing");
    endtask

    task automatic busyStartIgnored();
        int cycles;
        int extraDone;
        bit seen;
        startOp(1'b0, KeyA, PlainA);
        repeat (3) @(posedge clk);
        driveRequest(1'b1, KeyB, CipherB);
        @(posedge clk);
        start <= 1'b0;
        // four falling edges already passed since the accepting edge
        waitDone("busy start", cycles, seen);
        checkValue("busy start latency", ExpectedLatency, cycles + 4);
        checkValue("busy start result", CipherA, blockOut);
        extraDone = 0;
        for (int i = 0; i < 2 * ExpectedLatency; i++) begin
            @(negedge clk);
            if (done === 1'b1) begin
                extraDone++;
            end
        end
        checkValue("busy start extra done", 0, extraDone);
        finishTest("busy start");
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        request    = '0;
        seed       = 32'h6afb;
        testErrors = 0;
        passCount  = 0;
        failCount  = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        resetState();
        fipsVector("fips197 appendix c", KeyA, PlainA, CipherA);
        fipsVector("fips197 appendix b", KeyB, PlainB, CipherB);
        randomRoundTrip();
        doneTiming();
        busyStartIgnored();

        $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/aesCore.sv */
`timescale 1ns/100ps

module aesCore (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  aesTypesPkg::aesRequest_t request,
    output aesTypesPkg::state_t      blockOut,
    output logic                     done
);

    import aesTypesPkg::*;

    state_t     cipherKey;
    roundKeys_t roundKeys;
    state_t     roundState;
    state_t     roundKey;
    logic       lastRound;
    state_t     encNext;
    state_t     decNext;

    roundController uController (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .request    (request),
        .roundKeys  (roundKeys),
        .encNext    (encNext),
        .decNext    (decNext),
        .cipherKey  (cipherKey),
        .roundState (roundState),
        .roundKey   (roundKey),
        .lastRound  (lastRound),
        .blockOut   (blockOut),
        .done       (done)
    );

    keySchedule uKeySchedule (
        .cipherKey (cipherKey),
        .roundKeys (roundKeys)
    );

    // both directions evaluate every cycle, the controller picks one
    encryptRound uEncrypt (
        .roundState (roundState),
        .roundKey   (roundKey),
        .lastRound  (lastRound),
        .nextState  (encNext)
    );

    decryptRound uDecrypt (
        .roundState (roundState),
        .roundKey   (roundKey),
        .lastRound  (lastRound),
        .nextState  (decNext)
    );

endmodule

/* verilog/roundController.sv */
`timescale 1ns/100ps
`include "aes_settings.svh"

module roundController (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  aesTypesPkg::aesRequest_t request,
    input  aesTypesPkg::roundKeys_t  roundKeys,
    input  aesTypesPkg::state_t      encNext,
    input  aesTypesPkg::state_t      decNext,
    output aesTypesPkg::state_t      cipherKey,
    output aesTypesPkg::state_t      roundState,
    output aesTypesPkg::state_t      roundKey,
    output logic                     lastRound,
    output aesTypesPkg::state_t      blockOut,
    output logic                     done
);

    import aesTypesPkg::*;

    logic        busy;
    roundIndex_t counter;
    roundIndex_t keyIndex;
    aesRequest_t latched;
    state_t      stateReg;
    state_t      roundNext;

    // request is only sampled on the accepting edge
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            latched <= request;
        end
    end

    assign cipherKey  = latched.key;
    assign roundState = stateReg;

    // decryption walks the schedule backwards, so counter 0 also gives key 10
    assign keyIndex  = latched.decrypt ? roundIndex_t'(`AES_ROUNDS - counter) : counter;
    assign roundKey  = roundKeys[keyIndex];
    assign lastRound = (counter == roundIndex_t'(`AES_ROUNDS));
    assign roundNext = latched.decrypt ? decNext : encNext;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            counter  <= '0;
            stateReg <= '0;
            blockOut <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy    <= 1'b1;
                    counter <= '0;
                end
            end else if (counter == '0) begin
                // whitening step
                stateReg <= latched.block ^ roundKey;
                counter  <= counter + 1'b1;
            end else begin
                stateReg <= roundNext;
                if (lastRound) begin
                    blockOut <= roundNext;
                    done     <= 1'b1;
                    busy     <= 1'b0;
                    counter  <= '0;
                end else begin
                    counter <= counter + 1'b1;
                end
            end
        end
    end

    doneSinglePulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done);

    counterInRange: assert property (@(posedge clk) disable iff (rst)
        counter <= roundIndex_t'(`AES_ROUNDS));

    // a run neither reloads the request nor restarts its count
    startIgnoredWhileBusy: assert property (@(posedge clk) disable iff (rst)
        busy && !lastRound |=> $stable(latched) && counter == $past(counter) + 1'b1);

endmodule

/* verilog/decryptRound.sv */
`timescale 1ns/100ps

module decryptRound (
    input  aesTypesPkg::state_t roundState,
    input  aesTypesPkg::state_t roundKey,
    input  logic                lastRound,
    output aesTypesPkg::state_t nextState
);

    import aesTypesPkg::*;
    import aesMathPkg::*;

    state_t shifted;
    state_t subbed;
    state_t keyed;

    assign shifted = invShiftRows(roundState);

    sBoxLayer #(
        .payloadT (state_t),
        .inverse  (1'b1)
    ) uInvSubBytes (
        .dataIn  (shifted),
        .dataOut (subbed)
    );

    assign keyed = subbed ^ roundKey;

    // key added before InvMixColumns, none in the final round
    assign nextState = lastRound ? keyed : invMixColumns(keyed);

endmodule

/* verilog/encryptRound.sv */
`timescale 1ns/100ps

module encryptRound (
    input  aesTypesPkg::state_t roundState,
    input  aesTypesPkg::state_t roundKey,
    input  logic                lastRound,
    output aesTypesPkg::state_t nextState
);

    import aesTypesPkg::*;
    import aesMathPkg::*;

    state_t subbed;
    state_t shifted;
    state_t mixed;

    sBoxLayer #(
        .payloadT (state_t),
        .inverse  (1'b0)
    ) uSubBytes (
        .dataIn  (roundState),
        .dataOut (subbed)
    );

    assign shifted = shiftRows(subbed);

    // final round skips MixColumns
    assign mixed = lastRound ? shifted : mixColumns(shifted);

    assign nextState = mixed ^ roundKey;

endmodule

/* verilog/keySchedule.sv */
`timescale 1ns/100ps
`include "aes_settings.svh"

module keySchedule (
    input  aesTypesPkg::state_t     cipherKey,
    output aesTypesPkg::roundKeys_t roundKeys
);

    import aesTypesPkg::*;
    import aesMathPkg::*;

    localparam int NumWords = `AES_COLUMNS * (`AES_ROUNDS + 1);

    word_t keyWords [NumWords];

    genvar r, c;

    // words 0..3 are the key itself
    for (c = 0; c < `AES_COLUMNS; c = c + 1) begin : gInitWords
        assign keyWords[c] = cipherKey[c];
    end

    for (r = 1; r <= `AES_ROUNDS; r = r + 1) begin : gExpand
        word_t rotated;
        word_t substituted;

        // RotWord on the last word of the previous round key
        assign rotated = {keyWords[`AES_COLUMNS * r - 1][1:3],
                          keyWords[`AES_COLUMNS * r - 1][0]};

        sBoxLayer #(
            .payloadT (word_t),
            .inverse  (1'b0)
        ) uSubWord (
            .dataIn  (rotated),
            .dataOut (substituted)
        );

        assign keyWords[`AES_COLUMNS * r] = keyWords[`AES_COLUMNS * (r - 1)] ^ substituted
                                            ^ {rcon[r], 24'h000000};

        for (c = 1; c < `AES_COLUMNS; c = c + 1) begin : gChain
            assign keyWords[`AES_COLUMNS * r + c] = keyWords[`AES_COLUMNS * (r - 1) + c]
                                                    ^ keyWords[`AES_COLUMNS * r + c - 1];
        end
    end

    for (r = 0; r <= `AES_ROUNDS; r = r + 1) begin : gPack
        for (c = 0; c < `AES_COLUMNS; c = c + 1) begin : gCol
            assign roundKeys[r][c] = keyWords[`AES_COLUMNS * r + c];
        end
    end

endmodule

/* verilog/sBoxLayer.sv */
`timescale 1ns/100ps
`include "aes_settings.svh"

module sBoxLayer #(
    parameter type payloadT = aesTypesPkg::word_t,
    parameter bit  inverse  = 1'b0
) (
    input  payloadT dataIn,
    output payloadT dataOut
);

    import aesTypesPkg::*;
    import aesMathPkg::*;

    localparam int NumBytes = $bits(payloadT) / `AES_BYTE_BITS;

    logic [$bits(payloadT)-1:0] flatIn;
    logic [$bits(payloadT)-1:0] flatOut;

    assign flatIn  = dataIn;
    assign dataOut = flatOut;

    genvar i;

    for (i = 0; i < NumBytes; i = i + 1) begin : gByte
        byte_t inByte;

        assign inByte = flatIn[i * `AES_BYTE_BITS +: `AES_BYTE_BITS];

        if (inverse) begin : gInv
            assign flatOut[i * `AES_BYTE_BITS +: `AES_BYTE_BITS] = invSBox[inByte];
        end else begin : gFwd
            assign flatOut[i * `AES_BYTE_BITS +: `AES_BYTE_BITS] = sBox[inByte];
        end
    end

endmodule

/* verilog/aesMathPkg.sv */
`include "aes_settings.svh"

package aesMathPkg;

    import aesTypesPkg::*;

    // forward table, one row per high nibble
    localparam byte_t [0:255] sBox = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    localparam byte_t [0:255] invSBox = {
        128'h52096ad53036a538bf40a39e81f3d7fb,
        128'h7ce339829b2fff87348e4344c4dee9cb,
        128'h547b9432a6c2233dee4c950b42fac34e,
        128'h082ea16628d924b2765ba2496d8bd125,
        128'h72f8f66486689816d4a45ccc5d65b692,
        128'h6c704850fdedb9da5e154657a78d9d84,
        128'h90d8ab008cbcd30af7e45805b8b34506,
        128'hd02c1e8fca3f0f02c1afbd0301138a6b,
        128'h3a9111414f67dcea97f2cfcef0b4e673,
        128'h96ac7422e7ad3585e2f937e81c75df6e,
        128'h47f11a711d29c5896fb7620eaa18be1b,
        128'hfc563e4bc6d279209adbc0fe78cd5af4,
        128'h1fdda8338807c731b11210592780ec5f,
        128'h60517fa919b54a0d2de57a9f93c99cef,
        128'ha0e03b4dae2af5b0c8ebbb3c83539961,
        128'h172b047eba77d626e169146355210c7d
    };

    // round r uses rcon[r]
    localparam byte_t [1:`AES_ROUNDS] rcon = {
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    function automatic byte_t xtime(byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // row r rotates left by r columns
    function automatic state_t shiftRows(state_t s);
        state_t res;
        for (int c = 0; c < `AES_COLUMNS; c++) begin
            for (int r = 0; r < 4; r++) begin
                res[c][r] = s[(c + r) % `AES_COLUMNS][r];
            end
        end
        return res;
    endfunction

    function automatic state_t invShiftRows(state_t s);
        state_t res;
        for (int c = 0; c < `AES_COLUMNS; c++) begin
            for (int r = 0; r < 4; r++) begin
                res[c][r] = s[(c - r + `AES_COLUMNS) % `AES_COLUMNS][r];
            end
        end
        return res;
    endfunction

    // 2a ^ 3b ^ c ^ d written as a ^ sum ^ 2(a ^ b)
    function automatic state_t mixColumns(state_t s);
        state_t res;
        byte_t colSum;
        for (int c = 0; c < `AES_COLUMNS; c++) begin
            colSum = s[c][0] ^ s[c][1] ^ s[c][2] ^ s[c][3];
            for (int r = 0; r < 4; r++) begin
                res[c][r] = s[c][r] ^ colSum ^ xtime(s[c][r] ^ s[c][(r + 1) % 4]);
            end
        end
        return res;
    endfunction

    // inverse matrix factors into a {05,00,04,00} premix followed by MixColumns
    function automatic state_t invMixColumns(state_t s);
        state_t pre;
        byte_t u;
        byte_t v;
        pre = s;
        for (int c = 0; c < `AES_COLUMNS; c++) begin
            u = xtime(xtime(s[c][0] ^ s[c][2]));
            v = xtime(xtime(s[c][1] ^ s[c][3]));
            pre[c][0] = s[c][0] ^ u;
            pre[c][1] = s[c][1] ^ v;
            pre[c][2] = s[c][2] ^ u;
            pre[c][3] = s[c][3] ^ v;
        end
        return mixColumns(pre);
    endfunction

endpackage

/* verilog/aesTypesPkg.sv */
`include "aes_settings.svh"

package aesTypesPkg;

    typedef logic [`AES_BYTE_BITS-1:0] byte_t;

    // four rows per column, row 0 in the top byte
    typedef byte_t [0:3] word_t;

    // column 0 in the top word, so byte 0 is the msb
    typedef word_t [0:`AES_COLUMNS-1] state_t;

    // indexed by round number
    typedef state_t [`AES_ROUNDS:0] roundKeys_t;

    typedef logic [$clog2(`AES_ROUNDS + 1)-1:0] roundIndex_t;

    typedef struct packed {
        logic   decrypt;
        state_t key;
        state_t block;
    } aesRequest_t;

endpackage

/* verilog/aes_settings.svh */
`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

// cipher rounds for a 128-bit key
`define AES_ROUNDS 10

// 32-bit columns in state and key
`define AES_COLUMNS 4

`define AES_BYTE_BITS 8

`endif
